// File: source/rvseed_pkg.sv
// shared widths, opcodes, control encodings and reset pc for the rvseed core; import with ::*
`default_nettype none

package rvseed_pkg;

    localparam int XLEN       = 32;
    localparam int ILEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 2 ** REG_ADDR_W;

    typedef logic [XLEN-1:0]       word_t;     // data, address, immediate
    typedef logic [ILEN-1:0]       inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // alu operations, pass_b serves lui
    typedef enum logic [1:0] {
        ALU_ADD    = 2'd0,
        ALU_SUB    = 2'd1,
        ALU_PASS_B = 2'd2
    } alu_op_e;

    // operand pairs as (a, b)
    typedef enum logic [1:0] {
        SRC_REG_REG = 2'd0,   // rs1, rs2
        SRC_REG_IMM = 2'd1,   // rs1, imm
        SRC_PC_IMM  = 2'd2,   // pc, imm
        SRC_PC_4    = 2'd3    // pc, 4 for the link value
    } alu_src_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_U = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } imm_sel_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD  = 3'b000;   // addi, add, sub
    localparam logic [2:0] F3_JALR = 3'b000;
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [6:0] F7_ADD  = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    localparam inst_t INST_EBREAK = 32'h0010_0073;

    localparam word_t INST_STEP = 32'd4;          // bytes per instruction
    localparam word_t RESET_PC  = 32'h8000_0000;

endpackage

`default_nettype wire

// File: source/ctrl_if.sv
// decoded control bundle, driven by the decoder and read by the execute and fetch units
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if import rvseed_pkg::*; ();

    alu_op_e   alu_op;
    alu_src_e  alu_src;
    word_t     imm;         // sign-extended, format chosen by decoder
    logic      reg_wen;     // already low for x0
    reg_addr_t reg_waddr;
    logic      branch;
    logic      branch_ne;   // bne when set, beq otherwise
    logic      jump;        // jal
    logic      jalr;
    logic      ebreak;

    modport dec (
        output alu_op, alu_src, imm, reg_wen, reg_waddr,
        output branch, branch_ne, jump, jalr, ebreak
    );

    modport exe (input alu_op, alu_src, imm, reg_wen, reg_waddr);

    modport fet (input branch, branch_ne, jump, jalr, ebreak, imm);

endinterface

`default_nettype wire

// File: source/fetch_unit.sv
// pc register, halt flag and next-pc selection; one instruction per clock
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import rvseed_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    ctrl_if.fet         ctrl,
    input  logic        zero,
    input  word_t       alu_res,
    input  word_t       jalr_target,
    output word_t       pc,
    output logic        halted
);

    word_t pc_q;
    logic  halted_q;
    word_t next_pc;
    word_t pc_plus4;
    word_t jal_target;
    logic  taken;

    assign pc_plus4   = pc_q + INST_STEP;
    assign jal_target = pc_q + ctrl.imm;

    // beq on equal, bne on not equal
    assign taken = ctrl.branch & (ctrl.branch_ne ? ~zero : zero);

    always_comb begin
        if (halted_q || ctrl.ebreak) begin
            next_pc = pc_q;                              // stay on the ebreak
        end else if (ctrl.jump) begin
            next_pc = jal_target;
        end else if (ctrl.jalr) begin
            next_pc = {jalr_target[XLEN-1:1], 1'b0};
        end else if (taken) begin
            next_pc = alu_res;                           // alu adds pc + imm on branches
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q     <= RESET_PC;
            halted_q <= 1'b0;
        end else begin
            pc_q     <= next_pc;
            halted_q <= halted_q | ctrl.ebreak;   // sticky until reset
        end
    end

    assign pc     = pc_q;
    assign halted = halted_q;

endmodule

`default_nettype wire

// File: source/decoder.sv
// instruction decode into the control bundle, register addresses and immediate
`timescale 1ns/1ps
`default_nettype none

module decoder import rvseed_pkg::*; (
    input  inst_t       inst,
    ctrl_if.dec         ctrl,
    output reg_addr_t   rs1_addr,
    output reg_addr_t   rs2_addr,
    output logic        unknown_code
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;

    alu_op_e    alu_op;
    alu_src_e   alu_src;
    imm_sel_e   imm_sel;
    logic       wen;
    logic       branch;
    logic       branch_ne;
    logic       jump;
    logic       jalr;
    logic       ebreak;
    logic       unknown;
    word_t      imm;

    assign opcode   = inst[6:0];
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign funct7   = inst[31:25];

    always_comb begin
        // defaults give a no-op
        alu_op    = ALU_ADD;
        alu_src   = SRC_REG_IMM;
        imm_sel   = IMM_I;
        wen       = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        jalr      = 1'b0;
        ebreak    = 1'b0;
        unknown   = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                wen     = (funct3 == F3_ADD);
                unknown = (funct3 != F3_ADD);
            end
            OPC_OP: begin
                alu_src = SRC_REG_REG;
                if (funct3 == F3_ADD && funct7 == F7_ADD) begin
                    wen = 1'b1;
                end else if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    alu_op = ALU_SUB;
                    wen    = 1'b1;
                end else begin
                    unknown = 1'b1;
                end
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                imm_sel = IMM_U;
                wen     = 1'b1;
            end
            OPC_AUIPC: begin
                alu_src = SRC_PC_IMM;
                imm_sel = IMM_U;
                wen     = 1'b1;
            end
            OPC_JAL: begin
                alu_src = SRC_PC_4;   // link value
                imm_sel = IMM_J;
                wen     = 1'b1;
                jump    = 1'b1;
            end
            OPC_JALR: begin
                alu_src = SRC_PC_4;
                wen     = (funct3 == F3_JALR);
                jalr    = (funct3 == F3_JALR);
                unknown = (funct3 != F3_JALR);
            end
            OPC_BRANCH: begin
                alu_src   = SRC_PC_IMM;   // branch target through the alu
                imm_sel   = IMM_B;
                branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne = (funct3 == F3_BNE);
                unknown   = !((funct3 == F3_BEQ) || (funct3 == F3_BNE));
            end
            OPC_SYSTEM: begin
                ebreak  = (inst == INST_EBREAK);
                unknown = (inst != INST_EBREAK);
            end
            default: unknown = 1'b1;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (imm_sel)
            IMM_U:   imm = {inst[31:12], 12'b0};
            IMM_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    assign ctrl.alu_op    = alu_op;
    assign ctrl.alu_src   = alu_src;
    assign ctrl.imm       = imm;
    assign ctrl.reg_wen   = wen & (rd != '0);   // x0 writes dropped
    assign ctrl.reg_waddr = rd;
    assign ctrl.branch    = branch;
    assign ctrl.branch_ne = branch_ne;
    assign ctrl.jump      = jump;
    assign ctrl.jalr      = jalr;
    assign ctrl.ebreak    = ebreak;
    assign unknown_code   = unknown;

endmodule

`default_nettype wire

// File: source/reg_file.sv
// 32 x 32-bit register file, two combinational reads and one clocked write, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module reg_file import rvseed_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  logic        wen,
    input  reg_addr_t   waddr,
    input  word_t       wdata,
    input  reg_addr_t   raddr1,
    input  reg_addr_t   raddr2,
    output word_t       rdata1,
    output word_t       rdata2
);

    word_t regs [1:REG_NUM-1];   // no storage behind x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // no bypass, a write shows up the cycle after the edge
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: source/exec_unit.sv
// operand select, alu, branch compare and writeback data; purely combinational
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rvseed_pkg::*; (
    ctrl_if.exe         ctrl,
    input  word_t       pc,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  logic        halted,
    output logic        zero,
    output word_t       alu_res,
    output word_t       jalr_target,
    output logic        wb_en,
    output reg_addr_t   wb_addr,
    output word_t       wb_data
);

    word_t op_a;
    word_t op_b;
    word_t diff;
    word_t res;

    always_comb begin
        case (ctrl.alu_src)
            SRC_REG_REG: begin
                op_a = rs1_data;
                op_b = rs2_data;
            end
            SRC_PC_IMM: begin
                op_a = pc;
                op_b = ctrl.imm;
            end
            SRC_PC_4: begin
                op_a = pc;
                op_b = INST_STEP;
            end
            default: begin          // reg, imm
                op_a = rs1_data;
                op_b = ctrl.imm;
            end
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:    res = op_a - op_b;
            ALU_PASS_B: res = op_b;
            default:    res = op_a + op_b;
        endcase
    end

    // compare on its own subtractor, the alu is busy with the target
    assign diff = rs1_data - rs2_data;
    assign zero = (diff == '0);

    assign jalr_target = rs1_data + ctrl.imm;   // bit 0 cleared in fetch
    assign alu_res     = res;

    assign wb_en   = ctrl.reg_wen & ~halted;
    assign wb_addr = ctrl.reg_waddr;
    assign wb_data = res;

endmodule

`default_nettype wire

// File: source/rvseed_core.sv
// single-cycle rv32i subset core top; pc out, instruction in, writeback shown on the commit port
`timescale 1ns/1ps
`default_nettype none

module rvseed_core import rvseed_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  inst_t       inst,
    output word_t       pc,
    output logic        unknown_code,
    output logic        halted,
    output logic        commit_en,
    output reg_addr_t   commit_addr,
    output word_t       commit_data
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      zero;
    word_t     alu_res;
    word_t     jalr_target;
    logic      wb_en;

    ctrl_if u_ctrl ();

    fetch_unit u_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (u_ctrl.fet),
        .zero        (zero),
        .alu_res     (alu_res),
        .jalr_target (jalr_target),
        .pc          (pc),
        .halted      (halted)
    );

    decoder u_decoder (
        .inst         (inst),
        .ctrl         (u_ctrl.dec),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .unknown_code (unknown_code)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .arst_n (arst_n),
        .wen    (commit_en),
        .waddr  (commit_addr),
        .wdata  (commit_data),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_unit u_exec (
        .ctrl        (u_ctrl.exe),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .halted      (halted),
        .zero        (zero),
        .alu_res     (alu_res),
        .jalr_target (jalr_target),
        .wb_en       (wb_en),
        .wb_addr     (commit_addr),
        .wb_data     (commit_data)
    );

    assign commit_en = wb_en & arst_n;   // no commit while in reset

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// testbench clock and reset source; 4 ns clock, active-low reset held for 4 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/core_checker.sv
// watches the core ports each rising edge and compares them with the current program row
`timescale 1ns/1ps
`default_nettype none

module core_checker import rvseed_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  word_t       pc,
    input  logic        halted,
    input  logic        unknown_code,
    input  logic        commit_en,
    input  reg_addr_t   commit_addr,
    input  word_t       commit_data,
    input  logic        row_hit,
    input  logic [63:0] row_name,
    input  logic        exp_en,
    input  reg_addr_t   exp_addr,
    input  word_t       exp_data,
    input  word_t       exp_next,
    input  logic        exp_unknown,
    output int          n_checks,
    output int          n_errors
);

    word_t       want_pc;     // next pc promised by the previous row
    logic        have_want;
    logic [63:0] want_name;
    int          reset_edges;

    task automatic compare_field(input logic [63:0] name, input logic [95:0] what,
                                 input word_t expected, input word_t actual);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("[FAIL] %0s %0s: expected 0x%0h, actual 0x%0h", name, what, expected, actual);
        end
    endtask

    initial begin
        n_checks    = 0;
        n_errors    = 0;
        have_want   = 1'b0;
        reset_edges = 0;
    end

    // values seen here are the ones from before the edge
    always @(posedge clk) begin
        if (!arst_n) begin
            if (reset_edges > 0) begin   // pc may still be unknown at the first edge
                compare_field("reset", "pc", RESET_PC, pc);
                compare_field("reset", "halted", 32'd0, {31'd0, halted});
                compare_field("reset", "commit_en", 32'd0, {31'd0, commit_en});
            end
            reset_edges++;
            want_pc   = RESET_PC;
            want_name = "reset";
            have_want = 1'b1;
        end else begin
            if (have_want) begin
                compare_field(want_name, "next pc", want_pc, pc);
            end
            if (!row_hit) begin
                n_errors++;
                $display("unexpected pc %h: no program row at this address", pc);
                have_want = 1'b0;
            end else begin
                compare_field(row_name, "commit_en", {31'd0, exp_en}, {31'd0, commit_en});
                if (exp_en) begin
                    compare_field(row_name, "commit_addr", {27'd0, exp_addr}, {27'd0, commit_addr});
                    compare_field(row_name, "commit_data", exp_data, commit_data);
                end
                compare_field(row_name, "unknown", {31'd0, exp_unknown}, {31'd0, unknown_code});
                want_pc   = exp_next;
                want_name = row_name;
                have_want = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/core_sva.sv
// assertions on pc, halt and commit port, bound into every rvseed_core instance
`timescale 1ns/1ps
`default_nettype none

module core_sva import rvseed_pkg::*; (
    input  wire         clk,
    input  wire         arst_n,
    input  word_t       pc,
    input  logic        halted,
    input  logic        commit_en,
    input  reg_addr_t   commit_addr
);

    int fail_count = 0;   // read by the testbench top

    a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n) halted |=> $stable(pc))
        else begin fail_count++; $error("pc moved while halted"); end

    a_no_commit_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !commit_en)
        else begin fail_count++; $error("register commit while halted"); end

    a_no_x0_commit: assert property (@(posedge clk) disable iff (!arst_n)
        commit_en |-> commit_addr != '0)
        else begin fail_count++; $error("commit to x0"); end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else begin fail_count++; $error("pc not word aligned"); end

endmodule

bind rvseed_core core_sva u_sva (.*);

`default_nettype wire

// File: testbench/tb_core.sv
// simulation top that holds the program table, instruction memory model, DUT and checker
`timescale 1ns/1ps
`default_nettype none

module tb_core import rvseed_pkg::*; ();

    logic        clk;
    logic        arst_n;
    inst_t       inst;
    word_t       pc;
    logic        unknown_code;
    logic        halted;
    logic        commit_en;
    reg_addr_t   commit_addr;
    word_t       commit_data;

    // program table with one row per instruction
    logic [63:0] tab_name  [32];
    word_t       tab_addr  [32];
    inst_t       tab_inst  [32];
    logic        tab_en    [32];
    reg_addr_t   tab_waddr [32];
    word_t       tab_wdata [32];
    word_t       tab_next  [32];
    logic        tab_unk   [32];
    int          visits    [32];
    int          n_rows = 0;

    int          row;
    logic        row_hit;
    logic [63:0] row_name;
    logic        exp_en;
    reg_addr_t   exp_addr;
    word_t       exp_data;
    word_t       exp_next;
    logic        exp_unknown;
    int          n_checks;
    int          n_errors;
    int          run_errors;
    int          cycles;

    tb_clk_gen   u_clk_gen (.*);
    rvseed_core  u_dut (.*);
    core_checker u_checker (.*);

    task automatic add_row(input logic [63:0] name, input word_t addr, input inst_t code,
                           input logic en, input reg_addr_t waddr, input word_t wdata,
                           input word_t next, input logic unk);
        tab_name[n_rows]  = name;
        tab_addr[n_rows]  = addr;
        tab_inst[n_rows]  = code;
        tab_en[n_rows]    = en;
        tab_waddr[n_rows] = waddr;
        tab_wdata[n_rows] = wdata;
        tab_next[n_rows]  = next;
        tab_unk[n_rows]   = unk;
        visits[n_rows]    = 0;
        n_rows++;
    endtask

    function automatic int find_row(input word_t addr);
        int hit;
        hit = -1;
        for (int i = 0; i < n_rows; i++) begin
            if (tab_addr[i] === addr) hit = i;
        end
        return hit;
    endfunction

    // instruction memory model follows pc combinationally
    always @(pc or n_rows) begin
        row     = find_row(pc);
        row_hit = (row >= 0);
        if (row_hit) begin
            inst        = tab_inst[row];
            row_name    = tab_name[row];
            exp_en      = tab_en[row];
            exp_addr    = tab_waddr[row];
            exp_data    = tab_wdata[row];
            exp_next    = tab_next[row];
            exp_unknown = tab_unk[row];
        end else begin
            inst        = {pc[24:0] ^ pc[31:7], 7'b0001011};   // custom-0 opcode decodes as unknown
            row_name    = "none";
            exp_en      = 1'b0;
            exp_addr    = '0;
            exp_data    = '0;
            exp_next    = '0;
            exp_unknown = 1'b1;
        end
    end

    initial begin
        run_errors = 0;
        //      name        addr          inst          en wa  wdata         next          unk
        add_row("addi x1",  32'h8000_0000, 32'h0050_0093, 1, 1,  32'h0000_0005, 32'h8000_0004, 0);
        add_row("addi x2",  32'h8000_0004, 32'hffd0_0113, 1, 2,  32'hffff_fffd, 32'h8000_0008, 0);
        add_row("add x3",   32'h8000_0008, 32'h0020_81b3, 1, 3,  32'h0000_0002, 32'h8000_000c, 0);
        add_row("sub x4",   32'h8000_000c, 32'h4020_8233, 1, 4,  32'h0000_0008, 32'h8000_0010, 0);
        add_row("sub x5",   32'h8000_0010, 32'h4041_82b3, 1, 5,  32'hffff_fffa, 32'h8000_0014, 0);
        add_row("addi x0",  32'h8000_0014, 32'h0070_8013, 0, 0,  32'h0000_0000, 32'h8000_0018, 0);
        add_row("lui",      32'h8000_0018, 32'h1234_5337, 1, 6,  32'h1234_5000, 32'h8000_001c, 0);
        add_row("auipc x7", 32'h8000_001c, 32'h0000_1397, 1, 7,  32'h8000_101c, 32'h8000_0020, 0);
        add_row("jal x8",   32'h8000_0020, 32'h00c0_046f, 1, 8,  32'h8000_0024, 32'h8000_002c, 0);
        add_row("auipc x9", 32'h8000_002c, 32'h0000_0497, 1, 9,  32'h8000_002c, 32'h8000_0030, 0);
        add_row("jalr",     32'h8000_0030, 32'h0154_8567, 1, 10, 32'h8000_0034, 32'h8000_0040, 0);
        add_row("beq nt",   32'h8000_0040, 32'h0020_8463, 0, 0,  32'h0000_0000, 32'h8000_0044, 0);
        add_row("beq t",    32'h8000_0044, 32'h0010_8463, 0, 0,  32'h0000_0000, 32'h8000_004c, 0);
        add_row("bne nt",   32'h8000_004c, 32'h0010_9463, 0, 0,  32'h0000_0000, 32'h8000_0050, 0);
        add_row("bne t",    32'h8000_0050, 32'hfe20_92e3, 0, 0,  32'h0000_0000, 32'h8000_0034, 0);
        add_row("jal x0",   32'h8000_0034, 32'h0280_006f, 0, 0,  32'h0000_0000, 32'h8000_005c, 0);
        add_row("unknown",  32'h8000_005c, 32'h0000_000b, 0, 0,  32'h0000_0000, 32'h8000_0060, 1);
        add_row("ebreak",   32'h8000_0060, INST_EBREAK,   0, 0,  32'h0000_0000, 32'h8000_0060, 0);

        cycles = 0;
        while (arst_n !== 1'b1 && cycles < 16) begin
            @(posedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            $display("reset was never released");
            run_errors++;
        end

        // count each row as it executes, until the core halts
        cycles = 0;
        while (halted !== 1'b1 && cycles < 64) begin
            if (row_hit) visits[row]++;
            @(posedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: core did not halt within 64 cycles");
            run_errors++;
        end else begin
            repeat (8) @(posedge clk);   // pc must stay on the ebreak
        end
        @(negedge clk);   // checker and assertions finish the last edge first

        for (int i = 0; i < n_rows; i++) begin
            if (visits[i] != 1) begin
                $display("row %0d (%0s) at %h ran %0d times instead of once",
                         i, tab_name[i], tab_addr[i], visits[i]);
                run_errors++;
            end
        end

        $display("core test done: %0d checks, %0d check errors, %0d run errors, %0d assert errors",
                 n_checks, n_errors, run_errors, u_dut.u_sva.fail_count);
        if (n_errors == 0 && run_errors == 0 && u_dut.u_sva.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
source/rvseed_pkg.sv
source/ctrl_if.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/exec_unit.sv
source/rvseed_core.sv
testbench/tb_clk_gen.sv
testbench/core_checker.sv
testbench/core_sva.sv
testbench/tb_core.sv

// File: Bender.yml
package:
  name: rvseed

sources:
  - source/rvseed_pkg.sv
  - source/ctrl_if.sv
  - source/fetch_unit.sv
  - source/decoder.sv
  - source/reg_file.sv
  - source/exec_unit.sv
  - source/rvseed_core.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/core_checker.sv
      - testbench/core_sva.sv
      - testbench/tb_core.sv
